//--- src/codec_pkg.sv
package codec_pkg;

    localparam int SAMPLE_WIDTH       = 24;  // dac sample width
    localparam int SLOT_WIDTH         = 32;  // bclk periods per channel slot
    localparam int BCLK_DIV           = 4;   // clk_soc cycles per bclk half period
    localparam int CCLK_DIV           = 4;   // clk_soc cycles per cclk half period
    localparam int FRAME_FIFO_DEPTH   = 4;   // stereo frames held in the i2s fifo
    localparam int RESET_STRETCH_BITS = 6;   // top bit high for 32 cycles
    localparam int CMD_COUNT          = 6;   // entries in the start-up list
    localparam int CMD_WIDTH          = 32;  // one spi control word

    // counter widths and terminal values, sized to the counters that use them
    localparam int CCLK_DIV_BITS = $clog2(CCLK_DIV);
    localparam logic [CCLK_DIV_BITS-1:0] CCLK_DIV_LAST = CCLK_DIV_BITS'(CCLK_DIV - 1);
    localparam int CMD_BIT_BITS = $clog2(CMD_WIDTH);
    localparam logic [CMD_BIT_BITS-1:0] CMD_BIT_LAST = CMD_BIT_BITS'(CMD_WIDTH - 1);
    localparam int CMD_INDEX_BITS = $clog2(CMD_COUNT);
    localparam logic [CMD_INDEX_BITS-1:0] CMD_INDEX_LAST = CMD_INDEX_BITS'(CMD_COUNT - 1);
    localparam int BCLK_DIV_BITS = $clog2(BCLK_DIV);
    localparam logic [BCLK_DIV_BITS-1:0] BCLK_DIV_LAST = BCLK_DIV_BITS'(BCLK_DIV - 1);
    localparam int SLOT_BIT_BITS = $clog2(SLOT_WIDTH);
    localparam logic [SLOT_BIT_BITS-1:0] SLOT_BIT_LAST = SLOT_BIT_BITS'(SLOT_WIDTH - 1);
    localparam int SLOT_PAD_BITS = SLOT_WIDTH - SAMPLE_WIDTH - 1;  // zeros after the lsb
    localparam int FIFO_PTR_BITS = $clog2(FRAME_FIFO_DEPTH);
    localparam logic [FIFO_PTR_BITS-1:0] FIFO_PTR_LAST = FIFO_PTR_BITS'(FRAME_FIFO_DEPTH - 1);
    localparam int FIFO_COUNT_BITS = $clog2(FRAME_FIFO_DEPTH + 1);
    localparam logic [FIFO_COUNT_BITS-1:0] FIFO_FULL_COUNT = FIFO_COUNT_BITS'(FRAME_FIFO_DEPTH);

    // spi control word: raw view for the shifter, field view for building and decoding
    typedef union packed {
        logic [CMD_WIDTH-1:0] raw;
        struct packed {
            logic [7:0]  chip_addr_rw;  // chip address 0, write
            logic [15:0] reg_addr;
            logic [7:0]  reg_data;
        } fields;
    } adau_command_t;

    localparam adau_command_t ADAU_INIT_COMMANDS [CMD_COUNT] = '{
        32'h00_4000_00,  // dummy write, latch toggle 1 of 3 selects spi mode
        32'h00_4000_00,  // dummy write 2
        32'h00_4000_00,  // dummy write 3
        32'h00_4000_01,  // R0 clock control, core clock on
        32'h00_402A_03,  // R42 dac control 0, both dac channels on
        32'h00_4015_00   // R21 serial port 0, codec slave, i2s format
    };

endpackage

//--- src/i2s_frame_if.sv
interface i2s_frame_if;

    logic [codec_pkg::SAMPLE_WIDTH-1:0] frame_l;  // left sample
    logic [codec_pkg::SAMPLE_WIDTH-1:0] frame_r;  // right sample
    logic                               write_frame;  // store both samples this cycle
    logic                               full;     // fifo holds FRAME_FIFO_DEPTH frames

    modport source (
        output frame_l,
        output frame_r,
        output write_frame,
        input  full
    );

    modport sink (
        input  frame_l,
        input  frame_r,
        input  write_frame,
        output full
    );

endinterface

//--- src/reset_stretcher.sv
module reset_stretcher (
    input  logic clk_soc,
    input  logic reset_i,
    input  logic pll_locked_i,
    output logic core_reset_o
);

    logic [codec_pkg::RESET_STRETCH_BITS-1:0] stretch_count;  // counts down to zero

    always_ff @(posedge clk_soc) begin
        if (reset_i || !pll_locked_i) begin
            stretch_count <= '1;  // re-arm the full stretch
        end else if (|stretch_count) begin
            stretch_count <= stretch_count - 1'b1;
        end
    end

    // top bit drops after half the count range, 32 cycles with 6 bits
    assign core_reset_o = stretch_count[codec_pkg::RESET_STRETCH_BITS-1];

endmodule

//--- src/adau_command_list.sv
module adau_command_list (
    input  logic                     clk_soc,
    input  logic                     reset_i,
    input  logic                     spi_ready_i,
    input  logic                     clatch_n_i,
    output codec_pkg::adau_command_t command_o,
    output logic                     command_valid_o,
    output logic                     init_done_o
);

    logic [codec_pkg::CMD_INDEX_BITS-1:0] cmd_index;  // table entry on offer
    logic                                 all_sent;   // last entry accepted by the spi master
    logic                                 latch_seen; // last frame has pulled clatch low
    logic                                 transfer;   // valid and ready in the same cycle

    assign transfer  = command_valid_o && spi_ready_i;
    assign command_o = codec_pkg::ADAU_INIT_COMMANDS[cmd_index];  // stable while valid

    // walk the table, one entry per handshake
    always_ff @(posedge clk_soc) begin
        if (reset_i) begin
            cmd_index       <= '0;
            command_valid_o <= 1'b0;
            all_sent        <= 1'b0;
        end else begin
            if (transfer) begin
                command_valid_o <= 1'b0;  // one idle cycle between commands
                if (cmd_index == codec_pkg::CMD_INDEX_LAST) begin
                    all_sent <= 1'b1;
                end else begin
                    cmd_index <= cmd_index + 1'b1;
                end
            end else if (!command_valid_o && !all_sent) begin
                command_valid_o <= 1'b1;  // offer the next entry
            end
        end
    end

    // init_done waits for the final latch frame to close
    always_ff @(posedge clk_soc) begin
        if (reset_i) begin
            latch_seen  <= 1'b0;
            init_done_o <= 1'b0;
        end else begin
            if (all_sent && !clatch_n_i) begin
                latch_seen <= 1'b1;
            end
            if (latch_seen && clatch_n_i) begin
                init_done_o <= 1'b1;  // sticky until reset
            end
        end
    end

endmodule

//--- src/adau_spi_master.sv
module adau_spi_master (
    input  logic                     clk_soc,
    input  logic                     reset_i,
    input  logic                     command_valid_i,
    input  codec_pkg::adau_command_t command_i,
    output logic                     spi_ready_o,
    output logic                     cclk_o,
    output logic                     cdata_o,
    output logic                     clatch_n_o
);

    logic                                busy;       // latch frame open, bits shifting
    logic                                gap;        // one cycle after the latch closes
    logic [codec_pkg::CCLK_DIV_BITS-1:0] div_count;  // cycles within a cclk half period
    logic [codec_pkg::CMD_BIT_BITS-1:0]  bit_count;  // bits already sent
    logic [codec_pkg::CMD_WIDTH-1:0]     shift_q;    // msb on the wire
    logic                                half_end;   // last cycle of a half period
    logic                                bit_end;    // cclk high phase ends, next bit

    assign spi_ready_o = !busy && !gap;
    assign clatch_n_o  = !busy;
    assign cdata_o     = busy && shift_q[codec_pkg::CMD_WIDTH-1];  // low between frames
    assign half_end    = div_count == codec_pkg::CCLK_DIV_LAST;
    assign bit_end     = busy && half_end && cclk_o;

    always_ff @(posedge clk_soc) begin
        if (reset_i) begin
            busy      <= 1'b0;
            gap       <= 1'b0;
            cclk_o    <= 1'b0;
            div_count <= '0;
            bit_count <= '0;
        end else if (spi_ready_o) begin
            if (command_valid_i) begin
                busy      <= 1'b1;  // clatch low from the next cycle
                div_count <= '0;
                bit_count <= '0;
            end
        end else if (gap) begin
            gap <= 1'b0;  // ready again next cycle
        end else begin
            if (half_end) begin
                div_count <= '0;
                cclk_o    <= ~cclk_o;
                if (cclk_o) begin  // falling cclk closes one bit
                    bit_count <= bit_count + 1'b1;
                    if (bit_count == codec_pkg::CMD_BIT_LAST) begin
                        busy <= 1'b0;  // raise clatch
                        gap  <= 1'b1;
                    end
                end
            end else begin
                div_count <= div_count + 1'b1;
            end
        end
    end

    // data moves only as cclk falls, so it holds through the high phase
    always_ff @(posedge clk_soc) begin
        if (spi_ready_o && command_valid_i) begin
            shift_q <= command_i.raw;
        end else if (bit_end) begin
            shift_q <= {shift_q[codec_pkg::CMD_WIDTH-2:0], 1'b0};
        end
    end

endmodule

//--- src/i2s_master.sv
module i2s_master (
    input  logic      clk_soc,
    input  logic      reset_i,
    i2s_frame_if.sink frames_i,
    output logic      bclk_o,
    output logic      lrclk_o,
    output logic      sdata_o
);

    logic [codec_pkg::SAMPLE_WIDTH-1:0]    fifo_l [codec_pkg::FRAME_FIFO_DEPTH];
    logic [codec_pkg::SAMPLE_WIDTH-1:0]    fifo_r [codec_pkg::FRAME_FIFO_DEPTH];
    logic [codec_pkg::FIFO_PTR_BITS-1:0]   wr_ptr;
    logic [codec_pkg::FIFO_PTR_BITS-1:0]   rd_ptr;
    logic [codec_pkg::FIFO_COUNT_BITS-1:0] fifo_count;  // frames stored
    logic                                  fifo_empty;
    logic                                  fifo_push;
    logic                                  fifo_pop;
    logic [codec_pkg::SAMPLE_WIDTH-1:0]    pop_l;       // zero on underrun
    logic [codec_pkg::SAMPLE_WIDTH-1:0]    pop_r;

    logic [codec_pkg::BCLK_DIV_BITS-1:0]   bclk_div;    // cycles within a bclk half period
    logic [codec_pkg::SLOT_BIT_BITS-1:0]   slot_bit;    // bclk periods into the slot
    logic                                  bclk_fall;   // bclk falls on this edge
    logic                                  slot_end;    // lrclk toggles on this edge
    logic                                  left_start;  // right slot ends, left slot begins
    logic [codec_pkg::SLOT_WIDTH-1:0]      slot_shift;  // msb on sdata
    logic [codec_pkg::SAMPLE_WIDTH-1:0]    right_hold;  // right sample of the current frame

    assign fifo_empty    = fifo_count == '0;
    assign frames_i.full = fifo_count == codec_pkg::FIFO_FULL_COUNT;
    assign fifo_push     = frames_i.write_frame && !frames_i.full;  // dropped while full
    assign fifo_pop      = left_start && !fifo_empty;
    assign pop_l         = fifo_empty ? '0 : fifo_l[rd_ptr];
    assign pop_r         = fifo_empty ? '0 : fifo_r[rd_ptr];

    assign bclk_fall  = bclk_o && bclk_div == codec_pkg::BCLK_DIV_LAST;
    assign slot_end   = bclk_fall && slot_bit == codec_pkg::SLOT_BIT_LAST;
    assign left_start = slot_end && lrclk_o;
    assign sdata_o    = slot_shift[codec_pkg::SLOT_WIDTH-1];

    // frame storage
    always_ff @(posedge clk_soc) begin
        if (fifo_push) begin
            fifo_l[wr_ptr] <= frames_i.frame_l;
            fifo_r[wr_ptr] <= frames_i.frame_r;
        end
    end

    always_ff @(posedge clk_soc) begin
        if (reset_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (fifo_push) begin
                wr_ptr <= (wr_ptr == codec_pkg::FIFO_PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == codec_pkg::FIFO_PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({fifo_push, fifo_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;  // none, or one in and one out
            endcase
        end
    end

    // bclk, lrclk and slot shifter, all stepping on falling bclk
    always_ff @(posedge clk_soc) begin
        if (reset_i) begin
            bclk_div   <= '0;
            bclk_o     <= 1'b0;
            lrclk_o    <= 1'b0;  // first slot after reset is a silent left slot
            slot_bit   <= '0;
            slot_shift <= '0;
            right_hold <= '0;
        end else begin
            if (bclk_div == codec_pkg::BCLK_DIV_LAST) begin
                bclk_div <= '0;
                bclk_o   <= ~bclk_o;
            end else begin
                bclk_div <= bclk_div + 1'b1;
            end

            if (slot_end) begin
                slot_bit <= '0;
                lrclk_o  <= ~lrclk_o;
                // leading zero gives the one bclk delay before the msb
                if (lrclk_o) begin
                    slot_shift <= {1'b0, pop_l, {codec_pkg::SLOT_PAD_BITS{1'b0}}};
                    right_hold <= pop_r;
                end else begin
                    slot_shift <= {1'b0, right_hold, {codec_pkg::SLOT_PAD_BITS{1'b0}}};
                end
            end else if (bclk_fall) begin
                slot_bit   <= slot_bit + 1'b1;
                slot_shift <= {slot_shift[codec_pkg::SLOT_WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

//--- src/codec_audio_top.sv
module codec_audio_top (
    input  logic                               clk_soc,
    input  logic                               reset_i,
    input  logic                               pll_locked_i,
    input  logic                               write_frame_i,
    input  logic [codec_pkg::SAMPLE_WIDTH-1:0] frame_l_i,
    input  logic [codec_pkg::SAMPLE_WIDTH-1:0] frame_r_i,
    output logic                               full_o,
    output logic                               init_done_o,
    output logic                               core_reset_o,
    output logic                               cclk_o,
    output logic                               cdata_o,
    output logic                               clatch_n_o,
    output logic                               bclk_o,
    output logic                               lrclk_o,
    output logic                               sdata_o
);

    codec_pkg::adau_command_t adau_command;  // command list to spi master
    logic                     adau_command_valid;
    logic                     spi_ready;

    i2s_frame_if frames ();

    // frame source side comes straight from the top ports
    assign frames.frame_l     = frame_l_i;
    assign frames.frame_r     = frame_r_i;
    assign frames.write_frame = write_frame_i;
    assign full_o             = frames.full;

    reset_stretcher stretch (
        .clk_soc      (clk_soc),
        .reset_i      (reset_i),
        .pll_locked_i (pll_locked_i),
        .core_reset_o (core_reset_o)
    );

    adau_command_list ctrl (
        .clk_soc         (clk_soc),
        .reset_i         (core_reset_o),
        .spi_ready_i     (spi_ready),
        .clatch_n_i      (clatch_n_o),  // init_done waits for the last frame
        .command_o       (adau_command),
        .command_valid_o (adau_command_valid),
        .init_done_o     (init_done_o)
    );

    adau_spi_master spi (
        .clk_soc         (clk_soc),
        .reset_i         (core_reset_o),
        .command_valid_i (adau_command_valid),
        .command_i       (adau_command),
        .spi_ready_o     (spi_ready),
        .cclk_o          (cclk_o),
        .cdata_o         (cdata_o),
        .clatch_n_o      (clatch_n_o)
    );

    i2s_master i2s (
        .clk_soc  (clk_soc),
        .reset_i  (core_reset_o),
        .frames_i (frames.sink),
        .bclk_o   (bclk_o),
        .lrclk_o  (lrclk_o),
        .sdata_o  (sdata_o)
    );

endmodule

//--- tb/codec_audio_props.sv
module codec_audio_props (
    input logic clk_soc,
    input logic reset_i,
    input logic core_reset_o,
    input logic clatch_n_o,
    input logic cclk_o,
    input logic cdata_o,
    input logic bclk_o,
    input logic lrclk_o,
    input logic init_done_o
);

    timeunit 1ns;
    timeprecision 1ps;

    latch_closed_in_reset: assert property (
        @(posedge clk_soc) disable iff (reset_i)
        core_reset_o |-> clatch_n_o
    ) else $error("clatch_n_o low while core_reset_o is high");

    // codec samples cdata on rising cclk
    cdata_stable_cclk_high: assert property (
        @(posedge clk_soc) disable iff (reset_i || core_reset_o)
        cclk_o && $past(cclk_o) |-> $stable(cdata_o)
    ) else $error("cdata_o moved during the cclk high phase");

    lrclk_on_bclk_fall: assert property (
        @(posedge clk_soc) disable iff (reset_i || core_reset_o)
        $changed(lrclk_o) |-> $fell(bclk_o)
    ) else $error("lrclk_o changed away from a falling bclk_o");

    init_done_sticky: assert property (
        @(posedge clk_soc) disable iff (reset_i)
        $fell(init_done_o) |-> $past(core_reset_o)
    ) else $error("init_done_o fell without a reset");

endmodule

bind codec_audio_top codec_audio_props codec_audio_props_i (
    .clk_soc      (clk_soc),
    .reset_i      (reset_i),
    .core_reset_o (core_reset_o),
    .clatch_n_o   (clatch_n_o),
    .cclk_o       (cclk_o),
    .cdata_o      (cdata_o),
    .bclk_o       (bclk_o),
    .lrclk_o      (lrclk_o),
    .init_done_o  (init_done_o)
);

//--- tb/codec_audio_tb.sv
module codec_audio_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED       = 99186;
    localparam int FRAME_BITS = 2 * codec_pkg::SAMPLE_WIDTH;  // {left, right}
    // start-up is 6 commands of about 260 cycles, audio about 12 frames of 512 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic                               clk_soc;
    logic                               reset_i;
    logic                               pll_locked_i;
    logic                               write_frame_i;
    logic [codec_pkg::SAMPLE_WIDTH-1:0] frame_l_i;
    logic [codec_pkg::SAMPLE_WIDTH-1:0] frame_r_i;
    logic                               full_o;
    logic                               init_done_o;
    logic                               core_reset_o;
    logic                               cclk_o;
    logic                               cdata_o;
    logic                               clatch_n_o;
    logic                               bclk_o;
    logic                               lrclk_o;
    logic                               sdata_o;

    logic [codec_pkg::CMD_WIDTH-1:0] spi_words [$];    // one entry per closed latch frame
    logic [FRAME_BITS-1:0]           i2s_frames [$];   // rebuilt from sdata, left then right
    logic [FRAME_BITS-1:0]           sent_frames [$];  // accepted writes, oldest first
    int                              cycle_count = 0;

    codec_audio_top codec_audio_top_i (
        .clk_soc       (clk_soc),
        .reset_i       (reset_i),
        .pll_locked_i  (pll_locked_i),
        .write_frame_i (write_frame_i),
        .frame_l_i     (frame_l_i),
        .frame_r_i     (frame_r_i),
        .full_o        (full_o),
        .init_done_o   (init_done_o),
        .core_reset_o  (core_reset_o),
        .cclk_o        (cclk_o),
        .cdata_o       (cdata_o),
        .clatch_n_o    (clatch_n_o),
        .bclk_o        (bclk_o),
        .lrclk_o       (lrclk_o),
        .sdata_o       (sdata_o)
    );

    initial clk_soc = 1'b0;
    always #10 clk_soc = ~clk_soc;  // 20 ns period

    always @(posedge clk_soc) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_failure($sformatf("Timeout: no result after %0d clock cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic compare_value(input logic [31:0] expected, input logic [31:0] actual,
                                 input string what);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Fail at %0t ns: %s, expected %0h, got %0h",
                                      $time, what, expected, actual));
        end
    endtask

    task automatic compare_frame(input logic [FRAME_BITS-1:0] expected,
                                 input logic [FRAME_BITS-1:0] actual, input string what);
        compare_value(32'(expected[FRAME_BITS-1 -: codec_pkg::SAMPLE_WIDTH]),
                      32'(actual[FRAME_BITS-1 -: codec_pkg::SAMPLE_WIDTH]), {what, " left"});
        compare_value(32'(expected[codec_pkg::SAMPLE_WIDTH-1:0]),
                      32'(actual[codec_pkg::SAMPLE_WIDTH-1:0]), {what, " right"});
    endtask

    // bits taken on rising cclk while the latch is open, word stored when it closes
    task automatic spi_monitor;
        logic                            cclk_prev;
        logic                            latch_prev;
        logic [codec_pkg::CMD_WIDTH-1:0] shift;
        int                              bit_count;
        cclk_prev  = 1'b0;
        latch_prev = 1'b1;
        shift      = '0;
        bit_count  = 0;
        forever begin
            @(negedge clk_soc);
            if (core_reset_o) begin
                bit_count = 0;
            end else begin
                if (!clatch_n_o && cclk_o && !cclk_prev) begin
                    shift = {shift[codec_pkg::CMD_WIDTH-2:0], cdata_o};  // msb first
                    bit_count++;
                end
                if (clatch_n_o && !latch_prev) begin
                    if (bit_count != codec_pkg::CMD_WIDTH) begin
                        stop_on_failure($sformatf("SPI latch closed after %0d bits", bit_count));
                    end else begin
                        spi_words.push_back(shift);
                    end
                    bit_count = 0;
                end
            end
            cclk_prev  = cclk_o;
            latch_prev = clatch_n_o;
        end
    endtask

    // one slot is 32 rising bclk edges: delay bit, 24 sample bits, pad zeros
    task automatic i2s_monitor;
        logic                               bclk_prev;
        logic                               slot_lr;
        logic                               have_left;
        logic [codec_pkg::SLOT_WIDTH-1:0]   slot;
        logic [codec_pkg::SAMPLE_WIDTH-1:0] left;
        int                                 bit_count;
        bclk_prev = 1'b0;
        slot_lr   = 1'b0;
        have_left = 1'b0;
        slot      = '0;
        left      = '0;
        bit_count = 0;
        forever begin
            @(negedge clk_soc);
            if (core_reset_o) begin
                bit_count = 0;
                have_left = 1'b0;
            end else if (bclk_o && !bclk_prev) begin
                slot = {slot[codec_pkg::SLOT_WIDTH-2:0], sdata_o};
                bit_count++;
                if (bit_count == 1) begin
                    slot_lr = lrclk_o;
                end
                if (bit_count == codec_pkg::SLOT_WIDTH) begin
                    bit_count = 0;
                    if (lrclk_o != slot_lr) begin
                        stop_on_failure("I2S lrclk changed in the middle of a slot");
                    end
                    if (slot[codec_pkg::SLOT_WIDTH-1] || |slot[codec_pkg::SLOT_PAD_BITS-1:0]) begin
                        stop_on_failure("I2S slot carries ones outside the 24-bit sample");
                    end
                    if (!lrclk_o) begin
                        left      = slot[codec_pkg::SLOT_WIDTH-2 -: codec_pkg::SAMPLE_WIDTH];
                        have_left = 1'b1;
                    end else if (have_left) begin
                        i2s_frames.push_back({left,
                            slot[codec_pkg::SLOT_WIDTH-2 -: codec_pkg::SAMPLE_WIDTH]});
                        have_left = 1'b0;
                    end
                end
            end
            bclk_prev = bclk_o;
        end
    endtask

    function automatic logic [codec_pkg::SAMPLE_WIDTH-1:0] random_sample();
        logic [31:0] word;
        word = '0;
        while (word[codec_pkg::SAMPLE_WIDTH-1:0] == '0) begin
            word = $urandom;  // zero would be mistaken for underrun
        end
        return word[codec_pkg::SAMPLE_WIDTH-1:0];
    endfunction

    task automatic push_frame(input logic [FRAME_BITS-1:0] frame);
        while (full_o) begin
            @(posedge clk_soc);
            #2;
        end
        write_frame_i = 1'b1;
        {frame_l_i, frame_r_i} = frame;
        @(posedge clk_soc);
        #2;
        write_frame_i = 1'b0;
    endtask

    task automatic send_random_frames(input int count);
        logic [FRAME_BITS-1:0] frame;
        repeat (count) begin
            frame = {random_sample(), random_sample()};
            push_frame(frame);
            sent_frames.push_back(frame);
        end
    endtask

    task automatic take_stream_frame(output logic [FRAME_BITS-1:0] frame);
        while (i2s_frames.size() == 0) begin
            @(posedge clk_soc);
            #2;
        end
        frame = i2s_frames.pop_front();
    endtask

    // silent frames may lead, then the written frames follow in order
    task automatic expect_stream(input int count);
        logic [FRAME_BITS-1:0] got;
        take_stream_frame(got);
        while (got == '0) begin
            take_stream_frame(got);
        end
        for (int i = 0; i < count; i++) begin
            if (i > 0) begin
                take_stream_frame(got);
            end
            compare_frame(sent_frames.pop_front(), got, $sformatf("stream frame %0d", i));
        end
    endtask

    task automatic wait_left_slot_start;
        logic lr_prev;
        lr_prev = lrclk_o;
        @(posedge clk_soc);
        #2;
        while (!(lr_prev && !lrclk_o)) begin
            lr_prev = lrclk_o;
            @(posedge clk_soc);
            #2;
        end
    endtask

    task automatic follow_stretch;
        for (int i = 1; i <= 32; i++) begin  // core reset lasts 32 cycles
            @(posedge clk_soc);
            #2;
            compare_value(32'(i < 32), 32'(core_reset_o), $sformatf("core_reset_o, cycle %0d", i));
            compare_value(32'b100_0000, 32'({clatch_n_o, cclk_o, bclk_o, lrclk_o, sdata_o,
                          init_done_o, full_o}), "outputs during core reset");
        end
    endtask

    task automatic verify_reset_stretch;
        follow_stretch();
        pll_locked_i = 1'b0;  // lock lost for one cycle
        @(posedge clk_soc);
        #2;
        pll_locked_i = 1'b1;
        follow_stretch();
    endtask

    task automatic startup_sequence;
        codec_pkg::adau_command_t got;
        codec_pkg::adau_command_t expected;
        while (spi_words.size() < codec_pkg::CMD_COUNT) begin
            compare_value(32'd0, 32'(init_done_o), "init_done_o before the last latch closes");
            @(posedge clk_soc);
            #2;
        end
        compare_value(32'd1, 32'(init_done_o), "init_done_o after the last latch closes");
        for (int i = 0; i < codec_pkg::CMD_COUNT; i++) begin
            expected = codec_pkg::ADAU_INIT_COMMANDS[i];
            got.raw  = spi_words[i];
            compare_value(expected.raw, got.raw, $sformatf("command %0d word", i));
            compare_value(32'(expected.fields.chip_addr_rw), 32'(got.fields.chip_addr_rw),
                          $sformatf("command %0d chip address", i));
            compare_value(32'(expected.fields.reg_addr), 32'(got.fields.reg_addr),
                          $sformatf("command %0d register", i));
            compare_value(32'(expected.fields.reg_data), 32'(got.fields.reg_data),
                          $sformatf("command %0d data", i));
        end
    endtask

    task automatic stream_audio;
        send_random_frames(5);
        expect_stream(5);
    endtask

    task automatic fill_to_back_pressure;
        logic [FRAME_BITS-1:0] got;
        wait_left_slot_start();  // next pop is a full frame away
        for (int i = 0; i < codec_pkg::FRAME_FIFO_DEPTH; i++) begin
            send_random_frames(1);
            compare_value(32'(i == codec_pkg::FRAME_FIFO_DEPTH - 1), 32'(full_o),
                          $sformatf("full_o after write %0d", i));
        end
        write_frame_i = 1'b1;  // this one must be dropped
        frame_l_i     = random_sample();
        frame_r_i     = random_sample();
        @(posedge clk_soc);
        #2;
        write_frame_i = 1'b0;
        compare_value(32'd1, 32'(full_o), "full_o after the dropped write");
        expect_stream(codec_pkg::FRAME_FIFO_DEPTH);
        take_stream_frame(got);
        compare_frame('0, got, "frame after the stored ones");
    endtask

    task automatic drain_to_underrun;
        logic [FRAME_BITS-1:0] got;
        repeat (2) begin
            take_stream_frame(got);
            compare_frame('0, got, "underrun frame");
        end
        send_random_frames(3);
        expect_stream(3);
    endtask

    initial spi_monitor();
    initial i2s_monitor();

    initial begin
        void'($urandom(SEED));
        reset_i       = 1'b1;
        pll_locked_i  = 1'b1;
        write_frame_i = 1'b0;
        frame_l_i     = '0;
        frame_r_i     = '0;
        repeat (3) @(posedge clk_soc);
        #2;
        reset_i = 1'b0;
        verify_reset_stretch();
        startup_sequence();
        stream_audio();
        fill_to_back_pressure();
        drain_to_underrun();
        compare_value(32'(codec_pkg::CMD_COUNT), 32'(spi_words.size()), "SPI frames in the run");
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sim.f
src/codec_pkg.sv
src/i2s_frame_if.sv
src/reset_stretcher.sv
src/adau_command_list.sv
src/adau_spi_master.sv
src/i2s_master.sv
src/codec_audio_top.sv
tb/codec_audio_props.sv
tb/codec_audio_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the codec audio testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module codec_audio_tb \
    -o codec_audio_sim || { echo "verilator build failed"; exit 1; }
sim_out="$(./obj_dir/codec_audio_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Finished with no errors" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
